// File: flist.f
+incdir+include
logic/permPkg.sv
logic/resetNormalizer.sv
logic/topManager.sv
logic/permutationScorer.sv
logic/resultFifo.sv
logic/fullPermutationPipeline.sv
logic/OpenCLFullPermutationPipeline.sv
verif/permTb.sv

// File: logic/OpenCLFullPermutationPipeline.sv
`timescale 1ns/1ps

module OpenCLFullPermutationPipeline #(
    parameter int INIT_CYCLES = 16,
    parameter int FIFO_DEPTH  = 8
) (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 botValid,
    output logic                 botReady,
    input  logic                 startNewTop,  // Word on the bot lines is a new top
    input  logic [63:0]          botLower,
    input  logic [63:0]          botUpper,
    output logic                 resultValid,
    input  logic                 resultReady,
    output permPkg::resultWord_t result
);
    import permPkg::*;

    logic [VEC_WIDTH-1:0] heldWord;
    permKind_t            heldKind;
    logic                 rst;
    logic                 initialized;
    logic [VEC_WIDTH-1:0] top;
    logic                 stallInput;
    logic                 ackValid;
    logic                 creditOk;
    logic                 resultAvailable;
    logic                 topLoad;
    logic                 botWrite;
    logic                 grab;
    resultWord_t          fifoHead;

    // One deep input register, lets botReady go high long before startup ends
    always_ff @(posedge clock) begin
        if (!resetn) begin
            heldKind <= KIND_NONE;
        end else if (botReady) begin
            if (!botValid) begin
                heldKind <= KIND_NONE;
            end else if (startNewTop) begin
                heldKind <= KIND_TOP;
            end else begin
                heldKind <= KIND_BOT;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (botReady) begin
            heldWord <= {botUpper, botLower};
        end
    end

    assign botReady = ((heldKind == KIND_NONE) && !rst)
                   || (creditOk && initialized && !stallInput);

    assign topLoad  = botReady && (heldKind == KIND_TOP);
    assign botWrite = botReady && (heldKind == KIND_BOT);
    assign grab     = resultReady && resultAvailable;

    resetNormalizer #(.INIT_CYCLES(INIT_CYCLES)) rstNormalizer (
        .clock      (clock),
        .resetn     (resetn),
        .rst        (rst),
        .initialized(initialized)
    );

    topManager #(.FIFO_DEPTH(FIFO_DEPTH)) topMngr (
        .clock     (clock),
        .rst       (rst),
        .topWord   (heldWord),
        .topLoad   (topLoad),
        .botIn     (botWrite),
        .botOut    (grab),
        .ackTaken  (resultReady),
        .top       (top),
        .stallInput(stallInput),
        .ackValid  (ackValid)
    );

    fullPermutationPipeline #(.FIFO_DEPTH(FIFO_DEPTH)) permPipeline (
        .clock          (clock),
        .rst            (rst),
        .top            (top),
        .bot            (heldWord),
        .botWrite       (botWrite),
        .grab           (grab),
        .creditOk       (creditOk),
        .resultAvailable(resultAvailable),
        .result         (fifoHead)
    );

    // Ack only shows once the pipeline has drained, so no conflict with the FIFO head
    assign resultValid = resultAvailable || ackValid;
    assign result      = ackValid ? '0 : fifoHead;

endmodule

// File: logic/fullPermutationPipeline.sv
`timescale 1ns/1ps

module fullPermutationPipeline #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic [permPkg::VEC_WIDTH-1:0] top,
    input  logic [permPkg::VEC_WIDTH-1:0] bot,
    input  logic                          botWrite,
    input  logic                          grab,
    output logic                          creditOk,
    output logic                          resultAvailable,
    output permPkg::resultWord_t          result
);
    import permPkg::*;

    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);
    localparam int STAGES = 4;  // Three scorer stages plus the add stage

    // Source address of bit addr under ordering p of the three low address bits
    function automatic logic [ADDR_WIDTH-1:0] permAddr(input logic [ADDR_WIDTH-1:0] addr,
                                                       input int p);
        logic [ADDR_WIDTH-4:0] hi;
        logic [2:0]            lo;
        hi = addr[ADDR_WIDTH-1:3];
        lo = addr[2:0];
        case (p)
            0:       permAddr = {hi, lo[2], lo[1], lo[0]};
            1:       permAddr = {hi, lo[2], lo[0], lo[1]};
            2:       permAddr = {hi, lo[1], lo[2], lo[0]};
            3:       permAddr = {hi, lo[1], lo[0], lo[2]};
            4:       permAddr = {hi, lo[0], lo[2], lo[1]};
            default: permAddr = {hi, lo[0], lo[1], lo[2]};
        endcase
    endfunction

    logic [NUM_PERMS-1:0][scoreWidth-1:0] scores;
    logic [NUM_PERMS-1:0]                 nonzeros;
    logic [STAGES-1:0]                    validPipe;
    logic [FREE_W-1:0]                    freeSlots;
    logic [FREE_W-1:0]                    stageCount;
    logic [SUM_WIDTH-1:0]                 sumNext;
    logic [COUNT_WIDTH-1:0]               countNext;
    resultWord_t                          addWord;

    for (genvar p = 0; p < NUM_PERMS; p++) begin : g_perm
        logic [VEC_WIDTH-1:0] permBot;

        always_comb begin
            for (int a = 0; a < VEC_WIDTH; a++) begin
                permBot[a] = bot[permAddr(ADDR_WIDTH'(a), p)];
            end
        end

        permutationScorer scorer (
            .clock  (clock),
            .rst    (rst),
            .top    (top),
            .bot    (permBot),
            .score  (scores[p]),
            .nonzero(nonzeros[p])
        );
    end

    // Add stage
    always_comb begin
        sumNext   = '0;
        countNext = '0;
        for (int p = 0; p < NUM_PERMS; p++) begin
            sumNext   = sumNext + SUM_WIDTH'(scores[p]);
            countNext = countNext + COUNT_WIDTH'(nonzeros[p]);
        end
    end

    always_ff @(posedge clock) begin
        addWord.reserved <= '0;
        addWord.count    <= countNext;
        addWord.sum      <= sumNext;
    end

    // Valid bits travel beside the scorer data
    always_ff @(posedge clock) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[STAGES-2:0], botWrite};
        end
    end

    resultFifo #(.FIFO_DEPTH(FIFO_DEPTH)) queue (
        .clock    (clock),
        .rst      (rst),
        .push     (validPipe[STAGES-1]),
        .pushData (addWord),
        .pop      (grab),
        .head     (result),
        .notEmpty (resultAvailable),
        .freeSlots(freeSlots)
    );

    // Every bot in the stages already owns a FIFO slot
    always_comb begin
        stageCount = '0;
        for (int s = 0; s < STAGES; s++) begin
            stageCount = stageCount + FREE_W'(validPipe[s]);
        end
    end

    assign creditOk = (freeSlots > stageCount);

endmodule

// File: logic/permPkg.sv
package permPkg;

    // Vector geometry
    localparam int VEC_WIDTH  = 128;
    localparam int ADDR_WIDTH = 7;   // log2 of VEC_WIDTH
    localparam int NUM_PERMS  = 6;   // Orderings of the three swap variables

    // Result word fields
    localparam int SUM_WIDTH   = 48;
    localparam int COUNT_WIDTH = 13;

    // Squared overlap of one permutation, up to 128 * 128
    localparam int scoreWidth = 15;

    // Kind of the word sitting in the input holding register
    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_BOT,
        KIND_TOP
    } permKind_t;

    // Output word, shared by results and top acknowledgements
    typedef struct packed {
        logic [2:0]             reserved;  // Always zero, bit 63 was ECC status
        logic [COUNT_WIDTH-1:0] count;     // Nonzero overlaps
        logic [SUM_WIDTH-1:0]   sum;       // Sum of squared overlaps
    } resultWord_t;

endpackage

// File: logic/permutationScorer.sv
`timescale 1ns/1ps

module permutationScorer (
    input  logic                           clock,
    input  logic                           rst,
    input  logic [permPkg::VEC_WIDTH-1:0]  top,
    input  logic [permPkg::VEC_WIDTH-1:0]  bot,
    output logic [permPkg::scoreWidth-1:0] score,
    output logic                           nonzero
);
    import permPkg::*;

    localparam int NUM_GROUPS = VEC_WIDTH / 8;
    localparam int GROUP_W    = 4;                       // 0 to 8
    localparam int POP_W      = $clog2(VEC_WIDTH + 1);   // 0 to 128

    logic [VEC_WIDTH-1:0]               overlap;
    logic [NUM_GROUPS-1:0][GROUP_W-1:0] groupNext;
    logic [NUM_GROUPS-1:0][GROUP_W-1:0] groupCount;
    logic [POP_W-1:0]                   popNext;
    logic [POP_W-1:0]                   popCount;

    assign overlap = top & bot;

    // Stage one, byte wide popcounts
    always_comb begin
        for (int g = 0; g < NUM_GROUPS; g++) begin
            groupNext[g] = '0;
            for (int b = 0; b < 8; b++) begin
                groupNext[g] = groupNext[g] + GROUP_W'(overlap[g*8 + b]);
            end
        end
    end

    // Stage two, adder tree over the groups
    always_comb begin
        popNext = '0;
        for (int g = 0; g < NUM_GROUPS; g++) begin
            popNext = popNext + POP_W'(groupCount[g]);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            groupCount <= '0;
            popCount   <= '0;
            score      <= '0;
            nonzero    <= 1'b0;
        end else begin
            groupCount <= groupNext;
            popCount   <= popNext;
            // Stage three
            score      <= scoreWidth'(popCount) * scoreWidth'(popCount);
            nonzero    <= (popCount != '0);
        end
    end

endmodule

// File: logic/resetNormalizer.sv
`timescale 1ns/1ps

module resetNormalizer #(
    parameter int INIT_CYCLES = 16
) (
    input  logic clock,
    input  logic resetn,
    output logic rst,
    output logic initialized
);

    localparam int CNT_W = $clog2(INIT_CYCLES + 1);

    logic [CNT_W-1:0] initCount;

    // Internal active high reset, one cycle behind resetn
    always_ff @(posedge clock) begin
        rst <= !resetn;
    end

    // Startup delay so the input side stays closed for a while after reset
    always_ff @(posedge clock) begin
        if (rst) begin
            initCount   <= '0;
            initialized <= 1'b0;
        end else if (!initialized) begin
            initCount <= initCount + 1'b1;
            if (initCount == CNT_W'(INIT_CYCLES - 1)) begin
                initialized <= 1'b1;  // Stays up until next reset
            end
        end
    end

endmodule

// File: logic/resultFifo.sv
`timescale 1ns/1ps

module resultFifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               push,
    input  permPkg::resultWord_t               pushData,
    input  logic                               pop,
    output permPkg::resultWord_t               head,
    output logic                               notEmpty,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]    freeSlots
);
    import permPkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    resultWord_t      mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] occupancy;
    logic             doPush;
    logic             doPop;

    assign doPop  = pop && notEmpty;
    assign doPush = push && ((freeSlots != '0) || doPop);  // Full queue still takes a push on pop

    // Storage
    always_ff @(posedge clock) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            occupancy <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            occupancy <= occupancy + CNT_W'(doPush) - CNT_W'(doPop);
        end
    end

    assign head      = mem[rdPtr];  // Show-ahead read
    assign notEmpty  = (occupancy != '0);
    assign freeSlots = CNT_W'(FIFO_DEPTH) - occupancy;

endmodule

// File: logic/topManager.sv
`timescale 1ns/1ps

module topManager #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic [permPkg::VEC_WIDTH-1:0] topWord,
    input  logic                          topLoad,
    input  logic                          botIn,
    input  logic                          botOut,
    input  logic                          ackTaken,
    output logic [permPkg::VEC_WIDTH-1:0] top,
    output logic                          stallInput,
    output logic                          ackValid
);
    import permPkg::*;

    // Bots in flight never exceed the pipeline credit, which is bounded by the FIFO
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        TOP_IDLE,
        TOP_DRAIN,
        TOP_ACK
    } topState_t;

    topState_t            state;
    logic [CNT_W-1:0]     inFlight;
    logic [VEC_WIDTH-1:0] pendingTop;

    // Bots entered minus results delivered
    always_ff @(posedge clock) begin
        if (rst) begin
            inFlight <= '0;
        end else begin
            inFlight <= inFlight + CNT_W'(botIn) - CNT_W'(botOut);
        end
    end

    // New top is held aside until every older bot has been scored with the old one
    always_ff @(posedge clock) begin
        if (topLoad) begin
            pendingTop <= topWord;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= TOP_IDLE;
            top   <= '0;
        end else begin
            case (state)
                TOP_IDLE: begin
                    if (topLoad) begin
                        state <= TOP_DRAIN;
                    end
                end
                TOP_DRAIN: begin
                    if (inFlight == '0) begin
                        top   <= pendingTop;  // Pipeline empty, safe to swap
                        state <= TOP_ACK;
                    end
                end
                TOP_ACK: begin
                    if (ackTaken) begin
                        state <= TOP_IDLE;
                    end
                end
                default: state <= TOP_IDLE;
            endcase
        end
    end

    assign stallInput = (state != TOP_IDLE);
    assign ackValid   = (state == TOP_ACK);  // Zero word stands in for the top's result

endmodule

// File: include/permRef.svh
`ifndef PERM_REF_SVH
`define PERM_REF_SVH

// Source bit index for bit addr under ordering p of the three low address bits
function automatic int sourceIndex(input int addr, input int p);
    int b0;
    int b1;
    int b2;
    int hi;
    b0 = addr & 1;
    b1 = (addr >> 1) & 1;
    b2 = (addr >> 2) & 1;
    hi = addr & ~7;
    case (p)
        0:       return hi | (b2 << 2) | (b1 << 1) | b0;
        1:       return hi | (b2 << 2) | (b0 << 1) | b1;
        2:       return hi | (b1 << 2) | (b2 << 1) | b0;
        3:       return hi | (b1 << 2) | (b0 << 1) | b2;
        4:       return hi | (b0 << 2) | (b2 << 1) | b1;
        default: return hi | (b0 << 2) | (b1 << 1) | b2;
    endcase
endfunction

// Bot re-addressed by ordering p
function automatic logic [permPkg::VEC_WIDTH-1:0] permuteBot(
    input logic [permPkg::VEC_WIDTH-1:0] bot, input int p);
    logic [permPkg::VEC_WIDTH-1:0] permuted;
    for (int a = 0; a < permPkg::VEC_WIDTH; a++) begin
        permuted[a] = bot[sourceIndex(a, p)];
    end
    return permuted;
endfunction

// Popcount of top AND bot
function automatic int overlapCount(input logic [permPkg::VEC_WIDTH-1:0] top,
                                    input logic [permPkg::VEC_WIDTH-1:0] bot);
    return $countones(top & bot);
endfunction

// Expected output word for one bot against the current top
function automatic permPkg::resultWord_t scoreBot(
    input logic [permPkg::VEC_WIDTH-1:0] top, input logic [permPkg::VEC_WIDTH-1:0] bot);
    permPkg::resultWord_t word;
    int overlap;
    word = '0;
    for (int p = 0; p < permPkg::NUM_PERMS; p++) begin
        overlap = overlapCount(top, permuteBot(bot, p));
        word.sum = word.sum + permPkg::SUM_WIDTH'(overlap * overlap);
        if (overlap != 0) begin
            word.count = word.count + 1'b1;
        end
    end
    return word;
endfunction

`endif

// File: verif/permTb.sv
`timescale 1ns/1ps

module permTb;
    import permPkg::*;

    `include "permRef.svh"

    localparam int WAIT_LIMIT = 400;  // Cycles any single wait may take

    logic        clock;
    logic        resetn;
    logic        botValid;
    logic        botReady;
    logic        startNewTop;
    logic [63:0] botLower;
    logic [63:0] botUpper;
    logic        resultValid;
    logic        resultReady;
    resultWord_t result;

    integer               seed;
    int                   readyMode;   // 0 held low, 1 held high, otherwise random
    logic [VEC_WIDTH-1:0] modelTop;
    resultWord_t          expected[$];
    resultWord_t          expWord;
    int                   stallCount;
    int                   waited;

    OpenCLFullPermutationPipeline #(.INIT_CYCLES(16), .FIFO_DEPTH(8)) i_dut (
        .clock      (clock),
        .resetn     (resetn),
        .botValid   (botValid),
        .botReady   (botReady),
        .startNewTop(startNewTop),
        .botLower   (botLower),
        .botUpper   (botUpper),
        .resultValid(resultValid),
        .resultReady(resultReady),
        .result     (result)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
    endtask

    function automatic logic [VEC_WIDTH-1:0] randVec();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Offer one word and book its expected output once the DUT will take it
    task automatic sendWord(input logic isTop, input logic [VEC_WIDTH-1:0] data);
        int count;
        count = 0;
        @(posedge clock);
        botValid    <= 1'b1;
        startNewTop <= isTop;
        botLower    <= data[63:0];
        botUpper    <= data[127:64];
        @(negedge clock);
        while (!botReady) begin
            count++;
            if (count > WAIT_LIMIT) begin
                reportFailure("Timeout: botReady stayed low while an input word was offered");
                $fatal(1);
            end
            @(negedge clock);
        end
        if (isTop) begin
            modelTop = data;
            expected.push_back('0);  // Top only gets a zero ack
        end else begin
            expected.push_back(scoreBot(modelTop, data));
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clock);
            botValid <= 1'b0;
        end
        @(negedge clock);
    endtask

    task automatic waitDrain();
        int count;
        count = 0;
        while (expected.size() != 0) begin
            count++;
            if (count > WAIT_LIMIT) begin
                reportFailure("Timeout: expected results never came out of the DUT");
                $fatal(1);
            end
            @(negedge clock);
        end
    endtask

    always @(posedge clock) begin
        if (readyMode == 0) begin
            resultReady <= 1'b0;
        end else if (readyMode == 1) begin
            resultReady <= 1'b1;
        end else begin
            resultReady <= ($random(seed) & 1) != 0;
        end
    end

    // Output checker, sampled half a cycle away from the driving edge
    always @(negedge clock) begin
        if (resetn) begin
            assert (!resultValid || expected.size() > 0) else begin
                reportFailure("resultValid was high with no input waiting for a result");
                $fatal(1);
            end
            if (resultValid && resultReady) begin
                expWord = expected.pop_front();
                assert (result == expWord) else begin
                    reportFailure($sformatf("ERROR at %0t: result expected %h actual %h",
                                            $time, expWord, result));
                    $fatal(1);
                end
            end
            if (botValid && !botReady && !resultReady) begin
                stallCount++;
            end
        end
    end

    initial begin
        seed        = 32'h74e;
        readyMode   = 1;
        modelTop    = '0;
        stallCount  = 0;
        resetn      = 1'b0;
        botValid    = 1'b0;
        startNewTop = 1'b0;
        botLower    = '0;
        botUpper    = '0;
        resultReady = 1'b1;

        // Reference sanity against hand computed words
        assert (scoreBot('1, '1) == {3'b000, 13'd6, 48'd98304}) else begin
            reportFailure("Reference gives a wrong word for all ones top and bot");
            $fatal(1);
        end
        assert (scoreBot('1, {64{2'b01}}) == {3'b000, 13'd6, 48'd24576}) else begin
            reportFailure("Reference gives a wrong word for a half filled bot");
            $fatal(1);
        end

        repeat (4) @(posedge clock);
        @(negedge clock);
        assert (!botReady && !resultValid) else begin
            reportFailure("botReady or resultValid high during reset");
            $fatal(1);
        end
        @(posedge clock);
        resetn <= 1'b1;

        waited = 0;
        @(negedge clock);
        while (!botReady) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                reportFailure("Timeout: botReady never rose after reset");
                $fatal(1);
            end
            @(negedge clock);
        end
        idleCycles(20);  // Checker flags any output here

        // Known patterns
        sendWord(1'b1, '1);
        sendWord(1'b0, '1);
        sendWord(1'b0, {64{2'b01}});
        sendWord(1'b0, '0);
        sendWord(1'b1, {64{2'b10}});
        sendWord(1'b0, {16{8'h0f}});
        sendWord(1'b0, '1);
        idleCycles(1);
        waitDrain();

        // Long random run, tops land while bots are in flight
        for (int i = 0; i < 200; i++) begin
            sendWord(($random(seed) & 7) == 0, randVec() & randVec());
        end
        idleCycles(1);
        waitDrain();

        // Output held off long enough to fill the queue
        readyMode  = 0;
        stallCount = 0;
        fork
            begin
                for (int i = 0; i < 30; i++) begin
                    sendWord(i == 12, randVec());
                end
                idleCycles(1);
            end
            begin
                repeat (80) @(negedge clock);
                readyMode = 1;
            end
        join
        assert (stallCount > 0) else begin
            reportFailure("botReady never fell while the output was held off");
            $fatal(1);
        end
        waitDrain();

        // Random gaps on both sides
        readyMode = 2;
        for (int i = 0; i < 200; i++) begin
            if (($random(seed) & 3) == 0) begin
                idleCycles(1 + ($random(seed) & 3));
            end
            sendWord(($random(seed) & 7) == 0, randVec());
        end
        idleCycles(1);
        waitDrain();
        readyMode = 1;
        idleCycles(20);

        $display("TEST PASSED");
        $finish;
    end

endmodule
